//--- hw/x86_decode_pkg.sv
package x86_decode_pkg;

  // Register or operand value
  typedef logic [31:0] word_t;

  // Register number in x86 encoding order
  typedef logic [2:0] reg_sel_t;

  localparam reg_sel_t REG_EAX = 3'd0;
  localparam reg_sel_t REG_ECX = 3'd1;
  localparam reg_sel_t REG_EDX = 3'd2;
  localparam reg_sel_t REG_EBX = 3'd3;
  localparam reg_sel_t REG_ESP = 3'd4;
  localparam reg_sel_t REG_EBP = 3'd5;
  localparam reg_sel_t REG_ESI = 3'd6;
  localparam reg_sel_t REG_EDI = 3'd7;

  // First nine unescaped bytes, opcode in the low byte
  typedef logic [71:0] instr_bytes_t;

  // Instruction length in bytes, 1 to 11
  typedef logic [3:0] instr_len_t;

  // How the operands are encoded in the instruction
  typedef enum logic [3:0] {
    FORM_NONE       = 4'd0,
    FORM_REG        = 4'd1,
    FORM_REG_IMM    = 4'd2,
    FORM_IMM        = 4'd3,
    FORM_EAX_IMM    = 4'd4,
    FORM_EAX_REG    = 4'd5,
    FORM_RM         = 4'd6,
    FORM_RM_IMM     = 4'd7,
    FORM_RM_REG     = 4'd8,
    FORM_RM_REG_IMM = 4'd9,
    FORM_REG_RM     = 4'd10,
    FORM_REG_RM_IMM = 4'd11,
    FORM_DISP       = 4'd12
  } opnd_form_t;

  // Where operand 0 gets written back
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_kind_t;

  // One decoded instruction as seen by the next stage
  typedef struct packed {
    instr_len_t len;
    logic       disp_1byte;
    word_t      opnd0;
    word_t      opnd1;
    dest_kind_t dest0_kind;
    reg_sel_t   dest0_sel;
  } decoded_t;

  // Encoding analyzer result
  typedef struct packed {
    instr_len_t len;
    logic       disp_1byte;
    logic       rm_is_mem;
  } encoding_t;

  // Operand selector result
  typedef struct packed {
    word_t    opnd0;
    word_t    opnd1;
    reg_sel_t sel0;
    logic     opnd0_is_reg;
  } operands_t;

  // ModR/M forms where r/m supplies operand 0
  function automatic logic form_rm_first(input opnd_form_t form);
    return form inside {FORM_RM, FORM_RM_IMM, FORM_RM_REG, FORM_RM_REG_IMM};
  endfunction

  // ModR/M forms where reg supplies operand 0
  function automatic logic form_reg_first(input opnd_form_t form);
    return form inside {FORM_REG_RM, FORM_REG_RM_IMM};
  endfunction

endpackage

//--- hw/gpr_file.sv
module gpr_file (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_en,
  input  x86_decode_pkg::reg_sel_t    wr_sel,
  input  x86_decode_pkg::word_t       wr_data,
  output x86_decode_pkg::word_t [7:0] regs
);

  // One-hot write enable per register
  logic [7:0] wr_hit;

  always_comb begin
    wr_hit = '0;
    // Only the addressed register sees the strobe
    if (wr_en) begin
      wr_hit[wr_sel] = 1'b1;
    end
  end

  // Each register is its own flop bank
  genvar i;
  generate
    for (i = 0; i < 8; i++) begin : g_gpr
      always_ff @(posedge clk) begin
        if (rst) begin
          regs[i] <= '0;
        end else if (wr_hit[i]) begin
          // New value visible to decodes strobed from the next cycle on
          regs[i] <= wr_data;
        end
      end
    end
  endgenerate

  // All eight values leave in parallel
  // so both operand muxes can read in the same cycle

endmodule

//--- hw/modrm_analyzer.sv
module modrm_analyzer (
  input  x86_decode_pkg::instr_bytes_t instr,
  input  x86_decode_pkg::opnd_form_t   opnd_form,
  input  logic                         imm_1byte,
  input  logic                         prefix_operand_16bit,
  input  logic                         prefix_address_16bit,
  output x86_decode_pkg::encoding_t    enc
);

  // ModR/M sits right after the opcode
  logic [7:0] modrm;
  logic [1:0] modrm_mod;
  logic [2:0] modrm_rm;

  logic has_modrm;
  logic mod_is_reg;
  logic has_sib;
  logic has_imm;
  logic disp8;
  logic disp_full;

  x86_decode_pkg::instr_len_t disp_len;
  x86_decode_pkg::instr_len_t imm_len;

  assign modrm      = instr[15:8];
  assign modrm_mod  = modrm[7:6];
  assign modrm_rm   = modrm[2:0];
  assign mod_is_reg = (modrm_mod == 2'b11);

  // Every FORM_RM* and FORM_REG_RM* carries a ModR/M byte
  assign has_modrm = x86_decode_pkg::form_rm_first(opnd_form) ||
                     x86_decode_pkg::form_reg_first(opnd_form);

  // SIB only with 32-bit addressing, memory mode and r/m 100
  assign has_sib = has_modrm && !prefix_address_16bit && !mod_is_reg &&
                   (modrm_rm == 3'b100);

  // Short displacement
  assign disp8 = has_modrm && (modrm_mod == 2'b01);

  // Word-sized displacement, also the bare displacement form
  assign disp_full = (has_modrm && (modrm_mod == 2'b10)) ||
                     (has_modrm && (modrm_mod == 2'b00) && !prefix_address_16bit &&
                      (modrm_rm == 3'b101)) ||
                     (has_modrm && (modrm_mod == 2'b00) && prefix_address_16bit &&
                      (modrm_rm == 3'b110)) ||
                     (opnd_form == x86_decode_pkg::FORM_DISP);

  // Any form with IMM in its name
  assign has_imm = opnd_form inside {x86_decode_pkg::FORM_REG_IMM,
                                     x86_decode_pkg::FORM_IMM,
                                     x86_decode_pkg::FORM_EAX_IMM,
                                     x86_decode_pkg::FORM_RM_IMM,
                                     x86_decode_pkg::FORM_RM_REG_IMM,
                                     x86_decode_pkg::FORM_REG_RM_IMM};

  always_comb begin
    // Displacement bytes, 16-bit addressing shrinks the wide case
    if (disp8) begin
      disp_len = 4'd1;
    end else if (disp_full) begin
      disp_len = prefix_address_16bit ? 4'd2 : 4'd4;
    end else begin
      disp_len = 4'd0;
    end

    // Immediate bytes
    if (!has_imm) begin
      imm_len = 4'd0;
    end else if (imm_1byte) begin
      imm_len = 4'd1;
    end else begin
      imm_len = prefix_operand_16bit ? 4'd2 : 4'd4;
    end

    // Opcode plus optional ModR/M, SIB, displacement and immediate
    enc.len = 4'd1 + x86_decode_pkg::instr_len_t'(has_modrm) +
              x86_decode_pkg::instr_len_t'(has_sib) + disp_len + imm_len;
    enc.disp_1byte = disp8;
    // Operand 0 lives in memory
    enc.rm_is_mem  = has_modrm && x86_decode_pkg::form_rm_first(opnd_form) && !mod_is_reg;
  end

endmodule

//--- hw/operand_select.sv
module operand_select (
  input  x86_decode_pkg::instr_bytes_t instr,
  input  x86_decode_pkg::opnd_form_t   opnd_form,
  input  x86_decode_pkg::word_t [7:0]  regs,
  output x86_decode_pkg::operands_t    opnds
);

  // Eight-way register read
  function automatic x86_decode_pkg::word_t read_gpr(
    input x86_decode_pkg::word_t [7:0] file,
    input x86_decode_pkg::reg_sel_t    sel
  );
    case (sel)
      x86_decode_pkg::REG_EAX: return file[0];
      x86_decode_pkg::REG_ECX: return file[1];
      x86_decode_pkg::REG_EDX: return file[2];
      x86_decode_pkg::REG_EBX: return file[3];
      x86_decode_pkg::REG_ESP: return file[4];
      x86_decode_pkg::REG_EBP: return file[5];
      x86_decode_pkg::REG_ESI: return file[6];
      default:                 return file[7];
    endcase
  endfunction

  x86_decode_pkg::reg_sel_t opc_reg;
  x86_decode_pkg::reg_sel_t modrm_reg;
  x86_decode_pkg::reg_sel_t modrm_rm;
  logic                     mod_is_reg;
  logic                     rm_reg_second;

  x86_decode_pkg::reg_sel_t sel0;
  x86_decode_pkg::reg_sel_t sel1;
  logic                     has_reg0;
  logic                     has_reg1;

  // Register fields in the opcode and ModR/M bytes
  assign opc_reg    = instr[2:0];
  assign modrm_reg  = instr[13:11];
  assign modrm_rm   = instr[10:8];
  assign mod_is_reg = (instr[15:14] == 2'b11);

  // Forms where ModR/M reg supplies operand 1
  assign rm_reg_second = opnd_form inside {x86_decode_pkg::FORM_RM_REG,
                                           x86_decode_pkg::FORM_RM_REG_IMM};

  always_comb begin
    // Operand 0 selector
    has_reg0 = 1'b1;
    if (opnd_form inside {x86_decode_pkg::FORM_REG, x86_decode_pkg::FORM_REG_IMM}) begin
      sel0 = opc_reg;
    end else if (x86_decode_pkg::form_rm_first(opnd_form) && mod_is_reg) begin
      sel0 = modrm_rm;
    end else if (x86_decode_pkg::form_reg_first(opnd_form)) begin
      sel0 = modrm_reg;
    end else if (opnd_form inside {x86_decode_pkg::FORM_EAX_IMM,
                                   x86_decode_pkg::FORM_EAX_REG}) begin
      sel0 = x86_decode_pkg::REG_EAX;
    end else begin
      // Memory, immediate or no operand
      sel0     = x86_decode_pkg::REG_EAX;
      has_reg0 = 1'b0;
    end

    // Operand 1 selector
    has_reg1 = 1'b1;
    if (x86_decode_pkg::form_reg_first(opnd_form) && mod_is_reg) begin
      sel1 = modrm_rm;
    end else if (rm_reg_second) begin
      sel1 = modrm_reg;
    end else if (opnd_form == x86_decode_pkg::FORM_EAX_REG) begin
      sel1 = opc_reg;
    end else begin
      sel1     = x86_decode_pkg::REG_EAX;
      has_reg1 = 1'b0;
    end

    // Operands without a register source read as zero
    opnds.opnd0        = has_reg0 ? read_gpr(regs, sel0) : '0;
    opnds.opnd1        = has_reg1 ? read_gpr(regs, sel1) : '0;
    opnds.sel0         = sel0;
    opnds.opnd0_is_reg = has_reg0;
  end

endmodule

//--- hw/decode_latch.sv
module decode_latch (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  x86_decode_pkg::encoding_t enc,
  input  x86_decode_pkg::operands_t opnds,
  output logic                      out_valid,
  output x86_decode_pkg::decoded_t  out
);

  x86_decode_pkg::dest_kind_t dest_kind;
  x86_decode_pkg::decoded_t   rec_d;

  always_comb begin
    // Register destination wins over memory
    if (opnds.opnd0_is_reg) begin
      dest_kind = x86_decode_pkg::DEST_REG;
    end else if (enc.rm_is_mem) begin
      dest_kind = x86_decode_pkg::DEST_MEM;
    end else begin
      dest_kind = x86_decode_pkg::DEST_NONE;
    end

    // Merge both side-by-side results into one record
    rec_d.len        = enc.len;
    rec_d.disp_1byte = enc.disp_1byte;
    rec_d.opnd0      = opnds.opnd0;
    rec_d.opnd1      = opnds.opnd1;
    rec_d.dest0_kind = dest_kind;
    // Selector only meaningful for a register destination
    rec_d.dest0_sel  = (dest_kind == x86_decode_pkg::DEST_REG) ? opnds.sel0 : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out       <= '0;
    end else begin
      // One-cycle pulse per strobe
      out_valid <= in_valid;
      // Record holds until the next strobe
      if (in_valid) begin
        out <= rec_d;
      end
    end
  end

endmodule

//--- hw/x86_decode_top.sv
module x86_decode_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  x86_decode_pkg::instr_bytes_t instr,
  input  x86_decode_pkg::opnd_form_t   opnd_form,
  input  logic                         imm_1byte,
  input  logic                         prefix_operand_16bit,
  input  logic                         prefix_address_16bit,
  input  logic                         wr_en,
  input  x86_decode_pkg::reg_sel_t     wr_sel,
  input  x86_decode_pkg::word_t        wr_data,
  output logic                         out_valid,
  output x86_decode_pkg::decoded_t     out
);

  // Register values to the selector
  x86_decode_pkg::word_t [7:0] regs;
  // Side-by-side results into the latch
  x86_decode_pkg::encoding_t   enc;
  x86_decode_pkg::operands_t   opnds;

  gpr_file u_gpr_file (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .regs    (regs)
  );

  modrm_analyzer u_modrm_analyzer (
    .instr                (instr),
    .opnd_form            (opnd_form),
    .imm_1byte            (imm_1byte),
    .prefix_operand_16bit (prefix_operand_16bit),
    .prefix_address_16bit (prefix_address_16bit),
    .enc                  (enc)
  );

  operand_select u_operand_select (
    .instr     (instr),
    .opnd_form (opnd_form),
    .regs      (regs),
    .opnds     (opnds)
  );

  // Single pipeline register for the whole stage
  decode_latch u_decode_latch (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .enc       (enc),
    .opnds     (opnds),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

//--- testbench/tb_x86_decode.sv
module tb_x86_decode;

  localparam int DRIVE_DELAY = 5;
  localparam int WAIT_LIMIT = 8;

  logic                         clk;
  logic                         rst;
  logic                         in_valid;
  x86_decode_pkg::instr_bytes_t instr;
  x86_decode_pkg::opnd_form_t   opnd_form;
  logic                         imm_1byte;
  logic                         prefix_operand_16bit;
  logic                         prefix_address_16bit;
  logic                         wr_en;
  x86_decode_pkg::reg_sel_t     wr_sel;
  x86_decode_pkg::word_t        wr_data;
  logic                         out_valid;
  x86_decode_pkg::decoded_t     out;

  // Random source, shadow registers and counters
  logic [15:0]           lfsr_state;
  x86_decode_pkg::word_t shadow [8];
  int                    checks;
  int                    errors;
  int                    checks_base;
  int                    errors_base;

  x86_decode_top u_dut (
    .clk                  (clk),
    .rst                  (rst),
    .in_valid             (in_valid),
    .instr                (instr),
    .opnd_form            (opnd_form),
    .imm_1byte            (imm_1byte),
    .prefix_operand_16bit (prefix_operand_16bit),
    .prefix_address_16bit (prefix_address_16bit),
    .wr_en                (wr_en),
    .wr_sel               (wr_sel),
    .wr_data              (wr_data),
    .out_valid            (out_valid),
    .out                  (out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // 16-bit Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic x86_decode_pkg::instr_bytes_t rand_instr();
    x86_decode_pkg::instr_bytes_t ib;
    ib[31:0]  = rand_bits(32);
    ib[63:32] = rand_bits(32);
    ib[71:64] = 8'(rand_bits(8));
    return ib;
  endfunction

  function automatic x86_decode_pkg::opnd_form_t rand_form();
    logic [3:0] f;
    f = 4'(rand_bits(4) % 13);
    return x86_decode_pkg::opnd_form_t'(f);
  endfunction

  // Reference model of the whole stage, reads the shadow registers
  function automatic x86_decode_pkg::decoded_t expected_record(
    input x86_decode_pkg::opnd_form_t   form,
    input x86_decode_pkg::instr_bytes_t ib,
    input logic                         imm1,
    input logic                         op16,
    input logic                         ad16
  );
    logic [1:0] md;
    logic [2:0] rg;
    logic [2:0] rm;
    logic [2:0] opc;
    logic rm_first;
    logic reg_first;
    logic modrm;
    logic imm;
    logic src0;
    logic src1;
    x86_decode_pkg::reg_sel_t s0;
    x86_decode_pkg::reg_sel_t s1;
    int disp;
    int len_n;
    x86_decode_pkg::decoded_t d;
    md  = ib[15:14];
    rg  = ib[13:11];
    rm  = ib[10:8];
    opc = ib[2:0];
    rm_first = (form == x86_decode_pkg::FORM_RM) || (form == x86_decode_pkg::FORM_RM_IMM) ||
               (form == x86_decode_pkg::FORM_RM_REG) ||
               (form == x86_decode_pkg::FORM_RM_REG_IMM);
    reg_first = (form == x86_decode_pkg::FORM_REG_RM) ||
                (form == x86_decode_pkg::FORM_REG_RM_IMM);
    modrm = rm_first || reg_first;
    imm = (form == x86_decode_pkg::FORM_REG_IMM) || (form == x86_decode_pkg::FORM_IMM) ||
          (form == x86_decode_pkg::FORM_EAX_IMM) || (form == x86_decode_pkg::FORM_RM_IMM) ||
          (form == x86_decode_pkg::FORM_RM_REG_IMM) ||
          (form == x86_decode_pkg::FORM_REG_RM_IMM);
    // Displacement size
    disp = 0;
    if (!modrm) begin
      if (form == x86_decode_pkg::FORM_DISP) disp = ad16 ? 2 : 4;
    end else if (md == 2'b01) begin
      disp = 1;
    end else if (md == 2'b10) begin
      disp = ad16 ? 2 : 4;
    end else if (md == 2'b00 && ((!ad16 && rm == 3'd5) || (ad16 && rm == 3'd6))) begin
      disp = ad16 ? 2 : 4;
    end
    // Opcode, ModR/M, SIB, displacement, immediate
    len_n = 1 + disp;
    if (modrm) len_n++;
    if (modrm && !ad16 && md != 2'b11 && rm == 3'd4) len_n++;
    if (imm) len_n += imm1 ? 1 : (op16 ? 2 : 4);
    // Operand 0 source
    src0 = 1'b1;
    s0   = '0;
    case (form)
      x86_decode_pkg::FORM_REG, x86_decode_pkg::FORM_REG_IMM: s0 = opc;
      x86_decode_pkg::FORM_EAX_IMM, x86_decode_pkg::FORM_EAX_REG: s0 = x86_decode_pkg::REG_EAX;
      x86_decode_pkg::FORM_REG_RM, x86_decode_pkg::FORM_REG_RM_IMM: s0 = rg;
      default: begin
        if (rm_first && md == 2'b11) s0 = rm;
        else src0 = 1'b0;
      end
    endcase
    // Operand 1 source
    src1 = 1'b1;
    s1   = '0;
    if (reg_first && md == 2'b11) s1 = rm;
    else if (form == x86_decode_pkg::FORM_RM_REG ||
             form == x86_decode_pkg::FORM_RM_REG_IMM) s1 = rg;
    else if (form == x86_decode_pkg::FORM_EAX_REG) s1 = opc;
    else src1 = 1'b0;
    d = '0;
    d.len        = 4'(len_n);
    d.disp_1byte = (disp == 1);
    d.opnd0      = src0 ? shadow[s0] : '0;
    d.opnd1      = src1 ? shadow[s1] : '0;
    if (src0) begin
      d.dest0_kind = x86_decode_pkg::DEST_REG;
      d.dest0_sel  = s0;
    end else if (rm_first && md != 2'b11) begin
      d.dest0_kind = x86_decode_pkg::DEST_MEM;
    end else begin
      d.dest0_kind = x86_decode_pkg::DEST_NONE;
    end
    return d;
  endfunction

  task automatic compare_out(input x86_decode_pkg::decoded_t exp_rec, input string label);
    checks++;
    if (out !== exp_rec) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, label, out, exp_rec);
    end
  endtask

  task automatic write_reg(input x86_decode_pkg::reg_sel_t sel, input x86_decode_pkg::word_t data);
    wr_en   = 1'b1;
    wr_sel  = sel;
    wr_data = data;
    @(posedge clk);
    #DRIVE_DELAY;
    wr_en = 1'b0;
    shadow[sel] = data;
  endtask

  // One strobe, optional write in the same cycle, then wait for out_valid
  task automatic run_decode(
    input x86_decode_pkg::opnd_form_t   form,
    input x86_decode_pkg::instr_bytes_t ib,
    input logic                         imm1,
    input logic                         op16,
    input logic                         ad16,
    input logic                         do_wr,
    input x86_decode_pkg::reg_sel_t     wsel,
    input x86_decode_pkg::word_t        wdata,
    input string                        label
  );
    x86_decode_pkg::decoded_t exp_rec;
    int waited;
    exp_rec = expected_record(form, ib, imm1, op16, ad16);
    opnd_form            = form;
    instr                = ib;
    imm_1byte            = imm1;
    prefix_operand_16bit = op16;
    prefix_address_16bit = ad16;
    in_valid = 1'b1;
    wr_en    = do_wr;
    wr_sel   = wsel;
    wr_data  = wdata;
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
    wr_en    = 1'b0;
    if (do_wr) shadow[wsel] = wdata;
    waited = 1;
    while (!out_valid && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    if (!out_valid) begin
      $display("Timeout at %0t: out_valid never arrived for %s", $time, label);
      $display("Errors found");
      $finish;
    end else begin
      checks++;
      if (waited != 1) begin
        errors++;
        $display("MISMATCH at %0t: %s result after %0d cycles, expected 1", $time, label,
                 waited);
      end
      compare_out(exp_rec, label);
    end
  endtask

  task automatic start_test();
    checks_base = checks;
    errors_base = errors;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name, checks - checks_base,
             errors - errors_base);
  endtask

  initial begin
    x86_decode_pkg::instr_bytes_t ib;
    x86_decode_pkg::opnd_form_t   form;
    x86_decode_pkg::decoded_t     exp_rec;
    x86_decode_pkg::word_t        wval;
    logic                         send;
    in_valid             = 1'b0;
    instr                = '0;
    opnd_form            = x86_decode_pkg::FORM_NONE;
    imm_1byte            = 1'b0;
    prefix_operand_16bit = 1'b0;
    prefix_address_16bit = 1'b0;
    wr_en                = 1'b0;
    wr_sel               = '0;
    wr_data              = '0;
    rst                  = 1'b1;
    lfsr_state           = 16'd11012;
    checks               = 0;
    errors               = 0;
    exp_rec              = '0;
    for (int r = 0; r < 8; r++) shadow[r] = '0;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Zero after reset, then write every register and read it back
    start_test();
    // Output record and strobe cleared by reset
    checks++;
    if (out_valid !== 1'b0 || out !== '0) begin
      errors++;
      $display("MISMATCH at %0t: after reset out_valid %b out %h, expected all zero", $time,
               out_valid, out);
    end
    for (int r = 0; r < 8; r++) begin
      ib = rand_instr();
      ib[2:0] = 3'(r);
      run_decode(x86_decode_pkg::FORM_REG, ib, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, "reset read");
    end
    for (int r = 0; r < 8; r++) write_reg(3'(r), rand_bits(32));
    for (int r = 0; r < 8; r++) begin
      ib = rand_instr();
      ib[2:0] = 3'(r);
      run_decode(x86_decode_pkg::FORM_REG, ib, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, "written read");
    end
    // Write and decode in one cycle sees the old value
    ib = rand_instr();
    ib[2:0] = x86_decode_pkg::REG_EBX;
    wval = rand_bits(32);
    run_decode(x86_decode_pkg::FORM_REG, ib, 1'b0, 1'b0, 1'b0, 1'b1, x86_decode_pkg::REG_EBX,
               wval, "same-cycle write");
    run_decode(x86_decode_pkg::FORM_REG, ib, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, "after write");
    end_test(1, "reset and register write/read");

    // Register-direct ModR/M
    start_test();
    for (int n = 0; n < 24; n++) begin
      ib = rand_instr();
      ib[15:14] = 2'b11;
      form = rand_bit() ? x86_decode_pkg::FORM_RM_REG : x86_decode_pkg::FORM_REG_RM;
      run_decode(form, ib, rand_bit(), 1'b0, 1'b0, 1'b0, '0, '0, "reg-reg modrm");
    end
    end_test(2, "register-to-register modrm");

    // Opcode register and implicit eax
    start_test();
    for (int n = 0; n < 24; n++) begin
      ib = rand_instr();
      case (rand_bits(2) % 3)
        0: form = x86_decode_pkg::FORM_REG_IMM;
        1: form = x86_decode_pkg::FORM_EAX_IMM;
        default: form = x86_decode_pkg::FORM_EAX_REG;
      endcase
      run_decode(form, ib, rand_bit(), 1'b0, 1'b0, 1'b0, '0, '0, "opcode reg or eax");
    end
    end_test(3, "opcode-register and eax forms");

    // Lengths, 32-bit addressing
    start_test();
    for (int n = 0; n < 60; n++) begin
      form = rand_form();
      run_decode(form, rand_instr(), rand_bit(), 1'b0, 1'b0, 1'b0, '0, '0, "length 32");
    end
    end_test(4, "length in 32-bit addressing");

    // Lengths with random size prefixes
    start_test();
    for (int n = 0; n < 60; n++) begin
      form = rand_form();
      run_decode(form, rand_instr(), rand_bit(), rand_bit(), rand_bit(), 1'b0, '0, '0,
                 "length 16");
    end
    end_test(5, "length with 16-bit prefixes");

    // Strobes on consecutive cycles with random idle gaps
    start_test();
    for (int n = 0; n < 32; n++) begin
      send = (rand_bits(2) != 0);
      in_valid = send;
      if (send) begin
        form                 = rand_form();
        ib                   = rand_instr();
        opnd_form            = form;
        instr                = ib;
        imm_1byte            = rand_bit();
        prefix_operand_16bit = rand_bit();
        prefix_address_16bit = rand_bit();
        exp_rec = expected_record(form, ib, imm_1byte, prefix_operand_16bit,
                                  prefix_address_16bit);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      checks++;
      if (out_valid !== send) begin
        errors++;
        $display("MISMATCH at %0t: out_valid is %b after a cycle with in_valid %b", $time,
                 out_valid, send);
      end else if (send) begin
        compare_out(exp_rec, "back-to-back");
      end
    end
    in_valid = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    checks++;
    if (out_valid !== 1'b0) begin
      errors++;
      $display("MISMATCH at %0t: out_valid high on an idle cycle", $time);
    end
    end_test(6, "back-to-back strobes");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/x86_decode_pkg.sv
hw/gpr_file.sv
hw/modrm_analyzer.sv
hw/operand_select.sv
hw/decode_latch.sv
hw/x86_decode_top.sv
testbench/tb_x86_decode.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_x86_decode -o sim_x86_decode
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/sim_x86_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0
